/* hdl/mmio_pkg.sv */
package mmio_pkg;

    // bus widths
    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned DATA_WIDTH = 32;

    // ps/2 scan code width
    localparam int unsigned KB_WIDTH = 8;

    // address map
    // ram sits at the bottom, its length comes from the top-level RAM_WORDS
    localparam logic [ADDR_WIDTH-1:0] ADDR_RAM = 32'h0000_0000;
    localparam logic [ADDR_WIDTH-1:0] ADDR_KB  = 32'h1000_0000;
    localparam logic [ADDR_WIDTH-1:0] ADDR_SEG = 32'h1000_0010;

    // byte span of each peripheral window
    localparam logic [ADDR_WIDTH-1:0] PERI_LEN = 32'd16;

    // set in a keyboard read when a code came out of the buffer
    localparam int unsigned KB_VALID_BIT = 31;

    // access size of a load or store
    typedef enum logic [1:0] {
        W_BYTE,
        W_HALF,
        W_WORD
    } mem_width_e;

    // extension applied to byte and halfword loads
    typedef enum logic {
        L_SIGNED,
        L_UNSIGNED
    } load_kind_e;

endpackage

/* hdl/data_ram.sv */
module data_ram #(
    parameter int WORDS = 1024
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            ren,
    input  logic [$clog2(WORDS)-1:0]        raddr,
    input  logic [1:0]                      rlane,
    input  logic                            wen,
    input  logic [$clog2(WORDS)-1:0]        waddr,
    input  logic [1:0]                      wlane,
    input  logic [mmio_pkg::DATA_WIDTH-1:0] wdata,
    input  mmio_pkg::mem_width_e            width,
    input  mmio_pkg::mem_width_e            rwidth,
    input  mmio_pkg::load_kind_e            kind,
    output logic [mmio_pkg::DATA_WIDTH-1:0] rdata
);

    import mmio_pkg::*;

    localparam int LANES = DATA_WIDTH / 8;

    logic [DATA_WIDTH-1:0] mem [WORDS];
    logic [DATA_WIDTH-1:0] rword;
    logic [LANES-1:0]      be;
    logic [DATA_WIDTH-1:0] wline;
    logic [1:0]            r_lane;
    mem_width_e            r_width;
    load_kind_e            r_kind;
    logic [7:0]            rbyte;
    logic [15:0]           rhalf;

    // store data sits in the low bits, copy it onto every lane
    // and let the byte enables pick the addressed one
    always_comb begin
        case (width)
            W_BYTE: begin
                be    = LANES'(1) << wlane;
                wline = {LANES{wdata[7:0]}};
            end
            W_HALF: begin
                be    = LANES'(3) << wlane;
                wline = {(LANES / 2){wdata[15:0]}};
            end
            default: begin
                be    = '1;
                wline = wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            for (int i = 0; i < LANES; i++) begin
                if (be[i]) begin
                    mem[waddr][8*i +: 8] <= wline[8*i +: 8];
                end
            end
        end
    end

    // synchronous read, word comes out one cycle later
    always_ff @(posedge clk) begin
        if (ren) begin
            rword <= mem[raddr];
        end
    end

    // keep lane, size and kind alongside the word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_lane  <= 2'b00;
            r_width <= W_WORD;
            r_kind  <= L_UNSIGNED;
        end else if (ren) begin
            r_lane  <= rlane;
            r_width <= rwidth;
            r_kind  <= kind;
        end
    end

    // little endian lane select, then extend
    assign rbyte = rword[8*r_lane +: 8];
    assign rhalf = rword[16*r_lane[1] +: 16];

    always_comb begin
        case (r_width)
            W_BYTE: begin
                rdata = {{(DATA_WIDTH - 8){r_kind == L_SIGNED && rbyte[7]}}, rbyte};
            end
            W_HALF: begin
                rdata = {{(DATA_WIDTH - 16){r_kind == L_SIGNED && rhalf[15]}}, rhalf};
            end
            default: begin
                rdata = rword;
            end
        endcase
    end

    // halfword on an even lane, word on lane 0
    property p_aligned(logic en, mem_width_e w, logic [1:0] lane);
        @(posedge clk) disable iff (!rst_n)
        en |-> (w != W_HALF || !lane[0]) && (w != W_WORD || lane == 2'b00);
    endproperty

    a_wr_aligned: assert property (p_aligned(wen, width, wlane));
    a_rd_aligned: assert property (p_aligned(ren, rwidth, rlane));

endmodule

/* hdl/kb_buffer.sv */
module kb_buffer #(
    parameter int DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          push,
    input  logic [mmio_pkg::KB_WIDTH-1:0] push_data,
    input  logic                          pop,
    output logic [mmio_pkg::KB_WIDTH-1:0] head,
    output logic                          not_empty,
    output logic                          credit
);

    import mmio_pkg::*;

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [KB_WIDTH-1:0] slots [DEPTH];
    logic [PW-1:0]       wr_ptr;
    logic [PW-1:0]       rd_ptr;
    logic [CW-1:0]       count;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one slot freed, hand the credit back next cycle
            credit <= pop;
        end
    end

    assign head      = slots[rd_ptr];
    assign not_empty = (count != '0);

    // source must hold a credit, so a full buffer never sees a push
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n) push |-> count < CW'(DEPTH));

    // decoder only pops when a code is present
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> not_empty);

endmodule

/* hdl/seg_driver.sv */
module seg_driver #(
    parameter int SCAN_DIV = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            load,
    input  logic [mmio_pkg::DATA_WIDTH-1:0] load_value,
    output logic [mmio_pkg::DATA_WIDTH-1:0] value,
    output logic [7:0]                      an,
    output logic [6:0]                      cathode
);

    localparam int PW = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [PW-1:0] presc;
    logic [2:0]    digit;
    logic [3:0]    nibble;

    // full display word whatever the store size
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value <= '0;
        end else if (load) begin
            value <= load_value;
        end
    end

    // digit steps once per SCAN_DIV clocks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc <= '0;
            digit <= 3'd0;
        end else if (presc == PW'(SCAN_DIV - 1)) begin
            presc <= '0;
            // 7 wraps back to 0
            digit <= digit + 3'd1;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    assign an     = 8'b0000_0001 << digit;
    assign nibble = value[4*digit +: 4];

    // hex font in gfedcba order and active high
    always_comb begin
        case (nibble)
            4'h0:    cathode = 7'h3f;
            4'h1:    cathode = 7'h06;
            4'h2:    cathode = 7'h5b;
            4'h3:    cathode = 7'h4f;
            4'h4:    cathode = 7'h66;
            4'h5:    cathode = 7'h6d;
            4'h6:    cathode = 7'h7d;
            4'h7:    cathode = 7'h07;
            4'h8:    cathode = 7'h7f;
            4'h9:    cathode = 7'h6f;
            4'ha:    cathode = 7'h77;
            4'hb:    cathode = 7'h7c;
            4'hc:    cathode = 7'h39;
            4'hd:    cathode = 7'h5e;
            4'he:    cathode = 7'h79;
            default: cathode = 7'h71;
        endcase
    end

    a_an_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot(an));

endmodule

/* hdl/mmio.sv */
module mmio #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            mem_ren,
    input  logic [mmio_pkg::ADDR_WIDTH-1:0] mem_raddr,
    input  logic                            mem_wen,
    input  logic [mmio_pkg::ADDR_WIDTH-1:0] mem_waddr,
    output logic [mmio_pkg::DATA_WIDTH-1:0] mem_rdata,
    output logic                            mem_rvalid,
    output logic                            mem_err,
    output logic                            ram_ren,
    output logic                            ram_wen,
    input  logic [mmio_pkg::DATA_WIDTH-1:0] ram_rdata,
    output logic                            kb_pop,
    input  logic [mmio_pkg::KB_WIDTH-1:0]   kb_head,
    input  logic                            kb_not_empty,
    output logic                            seg_load,
    input  logic [mmio_pkg::DATA_WIDTH-1:0] seg_value
);

    import mmio_pkg::*;

    // where the pending read result comes from
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_RAM,
        SRC_KB,
        SRC_SEG
    } rd_src_e;

    localparam logic [ADDR_WIDTH-1:0] RAM_LEN = ADDR_WIDTH'(RAM_WORDS * 4);

    logic                  rd_ram;
    logic                  rd_kb;
    logic                  rd_seg;
    logic                  wr_ram;
    logic                  wr_seg;
    rd_src_e               rd_src;
    rd_src_e               src_q;
    logic [DATA_WIDTH-1:0] peri_word;
    logic [DATA_WIDTH-1:0] peri_q;
    logic                  valid_q;
    logic                  err_q;

    // offset compare, also fine for a window based at 0
    function automatic logic in_win(input logic [ADDR_WIDTH-1:0] addr,
                                    input logic [ADDR_WIDTH-1:0] base,
                                    input logic [ADDR_WIDTH-1:0] len);
        return (addr - base) < len;
    endfunction

    assign rd_ram = in_win(mem_raddr, ADDR_RAM, RAM_LEN);
    assign rd_kb  = in_win(mem_raddr, ADDR_KB, PERI_LEN);
    assign rd_seg = in_win(mem_raddr, ADDR_SEG, PERI_LEN);
    // keyboard window is read only
    assign wr_ram = in_win(mem_waddr, ADDR_RAM, RAM_LEN);
    assign wr_seg = in_win(mem_waddr, ADDR_SEG, PERI_LEN);

    always_comb begin
        if (rd_ram) begin
            rd_src = SRC_RAM;
        end else if (rd_kb) begin
            rd_src = SRC_KB;
        end else if (rd_seg) begin
            rd_src = SRC_SEG;
        end else begin
            rd_src = SRC_NONE;
        end
    end

    assign ram_ren  = mem_ren && rd_ram;
    assign ram_wen  = mem_wen && wr_ram;
    assign seg_load = mem_wen && wr_seg;
    // empty buffer reads as zero, no pop
    assign kb_pop   = mem_ren && rd_kb && kb_not_empty;

    // peripheral word sampled at the accept edge, before the pop moves the head
    always_comb begin
        peri_word = '0;
        if (rd_kb) begin
            if (kb_not_empty) begin
                peri_word[KB_WIDTH-1:0]  = kb_head;
                peri_word[KB_VALID_BIT] = 1'b1;
            end
        end else begin
            peri_word = seg_value;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_ren) begin
            peri_q <= peri_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_q   <= SRC_NONE;
            valid_q <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            src_q   <= mem_ren ? rd_src : SRC_NONE;
            valid_q <= mem_ren;
            // unmapped read, or write outside ram and display
            err_q   <= (mem_ren && rd_src == SRC_NONE) || (mem_wen && !(wr_ram || wr_seg));
        end
    end

    // result mux on the registered tag
    always_comb begin
        case (src_q)
            SRC_RAM:         mem_rdata = ram_rdata;
            SRC_KB, SRC_SEG: mem_rdata = peri_q;
            default:         mem_rdata = '0;
        endcase
    end

    assign mem_rvalid = valid_q;
    assign mem_err    = err_q;

    // exactly one result per accepted read, one cycle later
    a_rvalid_follows: assert property (
        @(posedge clk) disable iff (!rst_n) mem_ren |=> mem_rvalid);
    a_rvalid_only: assert property (
        @(posedge clk) disable iff (!rst_n) !mem_ren |=> !mem_rvalid);

    // a popped code shows up flagged in the result
    a_pop_flagged: assert property (
        @(posedge clk) disable iff (!rst_n) kb_pop |=> mem_rdata[KB_VALID_BIT]);

endmodule

/* hdl/mmio_top.sv */
module mmio_top #(
    parameter int RAM_WORDS = 1024,
    parameter int KB_DEPTH  = 4,
    parameter int SCAN_DIV  = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            mem_ren,
    input  logic [mmio_pkg::ADDR_WIDTH-1:0] mem_raddr,
    input  logic                            mem_wen,
    input  logic [mmio_pkg::ADDR_WIDTH-1:0] mem_waddr,
    input  logic [mmio_pkg::DATA_WIDTH-1:0] mem_wdata,
    input  mmio_pkg::mem_width_e            mem_width,
    input  mmio_pkg::load_kind_e            mem_kind,
    input  logic                            kb_push,
    input  logic [mmio_pkg::KB_WIDTH-1:0]   kb_data,
    output logic [mmio_pkg::DATA_WIDTH-1:0] mem_rdata,
    output logic                            mem_rvalid,
    output logic                            mem_err,
    output logic                            kb_credit,
    output logic [7:0]                      seg_an,
    output logic [6:0]                      seg_cathode
);

    import mmio_pkg::*;

    // word index bits of the ram
    localparam int RAM_AW = $clog2(RAM_WORDS);

    logic                  ram_ren;
    logic                  ram_wen;
    logic [DATA_WIDTH-1:0] ram_rdata;
    logic                  kb_pop;
    logic [KB_WIDTH-1:0]   kb_head;
    logic                  kb_not_empty;
    logic                  seg_load;
    logic [DATA_WIDTH-1:0] seg_value;

    mmio #(
        .RAM_WORDS    (RAM_WORDS)
    ) u_mmio (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_ren      (mem_ren),
        .mem_raddr    (mem_raddr),
        .mem_wen      (mem_wen),
        .mem_waddr    (mem_waddr),
        .mem_rdata    (mem_rdata),
        .mem_rvalid   (mem_rvalid),
        .mem_err      (mem_err),
        .ram_ren      (ram_ren),
        .ram_wen      (ram_wen),
        .ram_rdata    (ram_rdata),
        .kb_pop       (kb_pop),
        .kb_head      (kb_head),
        .kb_not_empty (kb_not_empty),
        .seg_load     (seg_load),
        .seg_value    (seg_value)
    );

    // byte address split into word index and lane
    data_ram #(
        .WORDS  (RAM_WORDS)
    ) u_ram (
        .clk    (clk),
        .rst_n  (rst_n),
        .ren    (ram_ren),
        .raddr  (mem_raddr[RAM_AW+1:2]),
        .rlane  (mem_raddr[1:0]),
        .wen    (ram_wen),
        .waddr  (mem_waddr[RAM_AW+1:2]),
        .wlane  (mem_waddr[1:0]),
        .wdata  (mem_wdata),
        .width  (mem_width),
        .rwidth (mem_width),
        .kind   (mem_kind),
        .rdata  (ram_rdata)
    );

    kb_buffer #(
        .DEPTH     (KB_DEPTH)
    ) u_kb (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (kb_push),
        .push_data (kb_data),
        .pop       (kb_pop),
        .head      (kb_head),
        .not_empty (kb_not_empty),
        .credit    (kb_credit)
    );

    seg_driver #(
        .SCAN_DIV   (SCAN_DIV)
    ) u_seg (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (seg_load),
        .load_value (mem_wdata),
        .value      (seg_value),
        .an         (seg_an),
        .cathode    (seg_cathode)
    );

endmodule

/* testbench/tb_mmio.sv */
module tb_mmio;

    import mmio_pkg::*;

    localparam int RAM_WORDS = 64;
    localparam int KB_DEPTH  = 4;
    localparam int SCAN_DIV  = 2;

    // sequence lengths that set the cycle limit
    localparam int N_WORDS      = 24;
    localparam int N_LANE_WORDS = 4;
    localparam int SCAN_WAIT    = 2 * 8 * SCAN_DIV;
    localparam int TEST_CYCLES  = 8 + 2 * N_WORDS + 24 * N_LANE_WORDS + 6 * KB_DEPTH + 16
                                  + 3 * (SCAN_WAIT + 4) + 24;
    localparam int MAX_CYCLES   = 2 * TEST_CYCLES;

    // hex font in gfedcba order and active high
    localparam logic [6:0] SEG_FONT [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    logic                  clk;
    logic                  rst_n;
    logic                  mem_ren;
    logic [ADDR_WIDTH-1:0] mem_raddr;
    logic                  mem_wen;
    logic [ADDR_WIDTH-1:0] mem_waddr;
    logic [DATA_WIDTH-1:0] mem_wdata;
    mem_width_e            mem_width;
    load_kind_e            mem_kind;
    logic                  kb_push;
    logic [KB_WIDTH-1:0]   kb_data;
    logic [DATA_WIDTH-1:0] mem_rdata;
    logic                  mem_rvalid;
    logic                  mem_err;
    logic                  kb_credit;
    logic [7:0]            seg_an;
    logic [6:0]            seg_cathode;

    // reference state
    logic [DATA_WIDTH-1:0] ram_model [RAM_WORDS];
    logic [KB_WIDTH-1:0]   kb_model [$];
    logic [DATA_WIDTH-1:0] seg_nxt;
    logic [DATA_WIDTH-1:0] seg_shown;
    int                    credits;

    // expected reply set with the stimulus and delayed one clock
    logic                  nxt_valid;
    logic [DATA_WIDTH-1:0] nxt_data;
    logic                  nxt_err;
    logic                  nxt_credit;
    logic                  exp_valid;
    logic [DATA_WIDTH-1:0] exp_data;
    logic                  exp_err;
    logic                  exp_credit;

    integer seed         = 32'h48a1_a106;
    int     cycle_cnt    = 0;
    int     reads_issued = 0;
    int     results_seen = 0;

    mmio_top #(
        .RAM_WORDS   (RAM_WORDS),
        .KB_DEPTH    (KB_DEPTH),
        .SCAN_DIV    (SCAN_DIV)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_ren     (mem_ren),
        .mem_raddr   (mem_raddr),
        .mem_wen     (mem_wen),
        .mem_waddr   (mem_waddr),
        .mem_wdata   (mem_wdata),
        .mem_width   (mem_width),
        .mem_kind    (mem_kind),
        .kb_push     (kb_push),
        .kb_data     (kb_data),
        .mem_rdata   (mem_rdata),
        .mem_rvalid  (mem_rvalid),
        .mem_err     (mem_err),
        .kb_credit   (kb_credit),
        .seg_an      (seg_an),
        .seg_cathode (seg_cathode)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("ERROR: %s expected 0x%h actual 0x%h", name, expected, actual);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        abort_run();
    endtask

    // pattern for whichever digit the anode selects
    function automatic logic [6:0] expected_segments(input logic [31:0] value,
                                                     input logic [7:0] an);
        int digit;
        digit = 0;
        for (int i = 0; i < 8; i++) begin
            if (an[i]) begin
                digit = i;
            end
        end
        return SEG_FONT[value[4*digit +: 4]];
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_valid  <= 1'b0;
            exp_data   <= '0;
            exp_err    <= 1'b0;
            exp_credit <= 1'b0;
            seg_shown  <= '0;
        end else begin
            exp_valid  <= nxt_valid;
            exp_data   <= nxt_data;
            exp_err    <= nxt_err;
            exp_credit <= nxt_credit;
            // display shows a store from the next cycle on
            seg_shown  <= seg_nxt;
        end
    end

    // results counted at the falling edge where outputs are stable
    always @(negedge clk) begin
        if (mem_rvalid) begin
            results_seen++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("timeout, run exceeded %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // checked from the second edge once reset has reached every register
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n && cycle_cnt > 0 |-> !mem_rvalid && !mem_err && !kb_credit && seg_an == 8'h01)
        else report_problem("outputs not idle or digit 0 not selected during reset");
    a_first_cycle: assert property (@(posedge clk)
        $rose(rst_n) |-> seg_an == 8'h01)
        else report_problem("seg_an left digit 0 in the first cycle after reset");
    a_valid: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rvalid == exp_valid)
        else show_mismatch("mem_rvalid", 32'($sampled(exp_valid)), 32'($sampled(mem_rvalid)));
    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        exp_valid |-> mem_rdata == exp_data)
        else show_mismatch("mem_rdata", $sampled(exp_data), $sampled(mem_rdata));
    a_err: assert property (@(posedge clk) disable iff (!rst_n)
        mem_err == exp_err)
        else show_mismatch("mem_err", 32'($sampled(exp_err)), 32'($sampled(mem_err)));
    // error result carries no data
    a_err_zero: assert property (@(posedge clk) disable iff (!rst_n)
        mem_err |-> mem_rdata == '0)
        else show_mismatch("mem_rdata", 32'h0, $sampled(mem_rdata));
    a_credit: assert property (@(posedge clk) disable iff (!rst_n)
        kb_credit == exp_credit)
        else show_mismatch("kb_credit", 32'($sampled(exp_credit)), 32'($sampled(kb_credit)));
    // more credits back than were spent would also leave the range
    a_credits_left: assert property (@(posedge clk) disable iff (!rst_n)
        credits >= 0 && credits <= KB_DEPTH)
        else report_problem("keyboard credit count left the range 0 to KB_DEPTH");
    a_an_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(seg_an))
        else report_problem("seg_an does not select exactly one digit");
    a_segments: assert property (@(posedge clk) disable iff (!rst_n)
        seg_cathode == expected_segments(seg_shown, seg_an))
        else show_mismatch("seg_cathode",
                           32'(expected_segments($sampled(seg_shown), $sampled(seg_an))),
                           32'($sampled(seg_cathode)));

    task automatic idle_inputs();
        mem_ren    = 1'b0;
        mem_raddr  = '0;
        mem_wen    = 1'b0;
        mem_waddr  = '0;
        mem_wdata  = '0;
        mem_width  = W_WORD;
        mem_kind   = L_UNSIGNED;
        kb_push    = 1'b0;
        kb_data    = '0;
        nxt_valid  = 1'b0;
        nxt_data   = '0;
        nxt_err    = 1'b0;
        nxt_credit = 1'b0;
    endtask

    // one clock back to the falling edge where a credit pulse is seen once
    task automatic advance();
        @(negedge clk);
        if (kb_credit) begin
            credits++;
        end
    endtask

    task automatic idle_cycles(input int n);
        idle_inputs();
        repeat (n) advance();
    endtask

    task automatic write_mem(input logic [31:0] addr, input logic [31:0] data,
                             input mem_width_e width);
        logic [1:0] lane;
        int         idx;
        lane = addr[1:0];
        idx  = addr >> 2;
        idle_inputs();
        mem_wen   = 1'b1;
        mem_waddr = addr;
        mem_wdata = data;
        mem_width = width;
        if (addr < RAM_WORDS * 4) begin
            case (width)
                W_BYTE:  ram_model[idx][8*lane +: 8] = data[7:0];
                W_HALF:  ram_model[idx][16*lane[1] +: 16] = data[15:0];
                default: ram_model[idx] = data;
            endcase
        end else if (addr >= ADDR_SEG && addr < ADDR_SEG + PERI_LEN) begin
            // whole word at any width
            seg_nxt = data;
        end else begin
            nxt_err = 1'b1;
        end
        advance();
    endtask

    task automatic read_mem(input logic [31:0] addr, input mem_width_e width,
                            input load_kind_e kind);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        logic [1:0]  lane;
        logic [7:0]  code;
        int          idx;
        lane = addr[1:0];
        idx  = addr >> 2;
        idle_inputs();
        mem_ren   = 1'b1;
        mem_raddr = addr;
        mem_width = width;
        mem_kind  = kind;
        nxt_valid = 1'b1;
        reads_issued++;
        if (addr < RAM_WORDS * 4) begin
            word = ram_model[idx];
            b    = word[8*lane +: 8];
            h    = word[16*lane[1] +: 16];
            case (width)
                W_BYTE:  nxt_data = (kind == L_SIGNED) ? {{24{b[7]}}, b} : {24'h0, b};
                W_HALF:  nxt_data = (kind == L_SIGNED) ? {{16{h[15]}}, h} : {16'h0, h};
                default: nxt_data = word;
            endcase
        end else if (addr >= ADDR_KB && addr < ADDR_KB + PERI_LEN) begin
            // empty buffer gives zero and no credit
            if (kb_model.size() > 0) begin
                code                   = kb_model.pop_front();
                nxt_data[7:0]          = code;
                nxt_data[KB_VALID_BIT] = 1'b1;
                nxt_credit             = 1'b1;
            end
        end else if (addr >= ADDR_SEG && addr < ADDR_SEG + PERI_LEN) begin
            nxt_data = seg_nxt;
        end else begin
            nxt_err = 1'b1;
        end
        advance();
    endtask

    // source holds off until it owns a credit
    task automatic push_code(input logic [7:0] code);
        idle_inputs();
        while (credits == 0) begin
            advance();
        end
        kb_push = 1'b1;
        kb_data = code;
        credits--;
        kb_model.push_back(code);
        advance();
    endtask

    initial begin
        int          idx;
        int          addrs [$];
        logic [31:0] base;
        logic [31:0] data;
        clk     = 1'b0;
        rst_n   = 1'b0;
        seg_nxt = '0;
        credits = KB_DEPTH;
        idle_inputs();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        advance();

        // random words then back-to-back reads in order
        for (int i = 0; i < N_WORDS; i++) begin
            idx = {$random(seed)} % RAM_WORDS;
            addrs.push_back(idx);
            write_mem(32'(idx * 4), $random(seed), W_WORD);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            read_mem(32'(addrs[i] * 4), W_WORD, L_UNSIGNED);
        end

        // byte and halfword stores with every lane loaded both ways
        for (int w = 0; w < N_LANE_WORDS; w++) begin
            idx  = {$random(seed)} % RAM_WORDS;
            base = 32'(idx * 4);
            write_mem(base, $random(seed), W_WORD);
            for (int l = 0; l < 2; l++) begin
                data    = $random(seed);
                // lane 0 positive and lane 1 negative
                data[7] = (l == 1);
                write_mem(base + l, data, W_BYTE);
            end
            data     = $random(seed);
            data[15] = w[0];
            write_mem(base + 2, data, W_HALF);
            for (int l = 0; l < 4; l++) begin
                read_mem(base + l, W_BYTE, L_SIGNED);
                read_mem(base + l, W_BYTE, L_UNSIGNED);
            end
            for (int l = 0; l < 4; l += 2) begin
                read_mem(base + l, W_HALF, L_SIGNED);
                read_mem(base + l, W_HALF, L_UNSIGNED);
            end
            read_mem(base, W_WORD, L_SIGNED);
        end

        // keyboard fill on credits then drain
        read_mem(ADDR_KB, W_WORD, L_UNSIGNED);
        while (credits > 0) begin
            push_code(8'($random(seed)));
        end
        for (int i = 0; i < KB_DEPTH; i++) begin
            read_mem(ADDR_KB, W_WORD, L_UNSIGNED);
        end
        push_code(8'($random(seed)));
        // readable the cycle after the push
        read_mem(ADDR_KB + 4, W_WORD, L_UNSIGNED);
        push_code(8'($random(seed)));
        push_code(8'($random(seed)));
        read_mem(ADDR_KB, W_WORD, L_UNSIGNED);
        read_mem(ADDR_KB, W_WORD, L_UNSIGNED);
        read_mem(ADDR_KB, W_WORD, L_UNSIGNED);

        // display byte store still loads the whole word
        write_mem(ADDR_SEG, $random(seed), W_BYTE);
        idle_cycles(SCAN_WAIT);
        read_mem(ADDR_SEG, W_WORD, L_UNSIGNED);
        write_mem(ADDR_SEG + 4, $random(seed), W_WORD);
        idle_cycles(SCAN_WAIT);
        read_mem(ADDR_SEG, W_WORD, L_UNSIGNED);

        // unmapped and read-only accesses
        write_mem(32'h0, $random(seed), W_WORD);
        read_mem(32'h2000_0000, W_WORD, L_UNSIGNED);
        read_mem(32'(RAM_WORDS * 4), W_WORD, L_UNSIGNED);
        read_mem(ADDR_SEG + PERI_LEN, W_WORD, L_UNSIGNED);
        // first address past the ram aliases word 0 in the low bits
        write_mem(32'(RAM_WORDS * 4), $random(seed), W_WORD);
        write_mem(ADDR_KB, $random(seed), W_WORD);
        write_mem(32'hffff_fffc, $random(seed), W_WORD);
        read_mem(32'h0, W_WORD, L_UNSIGNED);
        read_mem(ADDR_SEG, W_WORD, L_UNSIGNED);
        idle_cycles(4);

        if (credits != KB_DEPTH) begin
            $display("keyboard credits not all returned, source holds %0d", credits);
            abort_run();
        end else if (results_seen != reads_issued) begin
            $display("%0d read results seen for %0d reads issued", results_seen,
                     reads_issued);
            abort_run();
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

/* list.f */
hdl/mmio_pkg.sv
hdl/data_ram.sv
hdl/kb_buffer.sv
hdl/seg_driver.sv
hdl/mmio.sv
hdl/mmio_top.sv
testbench/tb_mmio.sv

/* Bender.yml */
package:
  name: mmio

sources:
  - files:
      - hdl/mmio_pkg.sv
      - hdl/data_ram.sv
      - hdl/kb_buffer.sv
      - hdl/seg_driver.sv
      - hdl/mmio.sv
      - hdl/mmio_top.sv
  - target: test
    files:
      - testbench/tb_mmio.sv
